/* hdl/dpc_defines.svh */
`ifndef DPC_DEFINES_SVH
`define DPC_DEFINES_SVH

// instructions tracked at once
// size it to the depth from fetch queue to issue
`define DPC_TRACE_INST_N 4

// instruction id width
`define DPC_INST_ID_WIDTH 4

// register index width (x0..x31)
`define DPC_REG_ID_WIDTH 5

`endif

/* hdl/dpc_pkg.sv */
`include "dpc_defines.svh"

package dpc_pkg;

	typedef logic [`DPC_INST_ID_WIDTH-1:0] inst_id_t; // in-flight instruction tag
	typedef logic [`DPC_REG_ID_WIDTH-1:0] reg_id_t; // gpr index
	typedef logic [$clog2(`DPC_TRACE_INST_N)-1:0] entry_idx_t; // table slot
	typedef logic [`DPC_TRACE_INST_N-1:0] entry_vec_t; // one bit per slot

	typedef enum logic [1:0] {
		STAGE_FREE,
		STAGE_IFQ, // sitting in fetch queue
		STAGE_DECODED,
		STAGE_DISPATCHED // waiting for retire
	} entry_stage_e;

	typedef struct packed {
		logic     valid;
		inst_id_t inst_id;
	} trace_evt_t; // decode / dispatch / retire strobe

	typedef struct packed {
		logic     valid;
		inst_id_t inst_id;
		reg_id_t  rd_id;
		logic     rd_vld;
	} enter_ifq_t;

	// zero in writes_rd_id means no gpr write
	typedef struct packed {
		entry_stage_e stage;
		reg_id_t      writes_rd_id;
	} entry_status_t;

	typedef struct packed {
		logic rs1_raw;
		logic rs2_raw;
		logic rd_waw;
	} hazard_flags_t;

endpackage

/* hdl/dpc_alloc.sv */
`timescale 1ns/10ps
`include "dpc_defines.svh"

module dpc_alloc (
	input  dpc_pkg::entry_vec_t entry_busy,
	input  dpc_pkg::enter_ifq_t enter_ifq,
	input  logic                sys_reset_req,
	input  logic                flush_req,
	output dpc_pkg::entry_vec_t entry_load,
	output logic                tb_full
);
	import dpc_pkg::*;

	entry_idx_t free_idx;
	logic       free_found;
	logic       alloc_en;

	// priority search, walking down so the lowest free slot wins
	always_comb begin
		free_idx   = '0;
		free_found = 1'b0;
		for (int i = `DPC_TRACE_INST_N - 1; i >= 0; i--) begin
			if (!entry_busy[i]) begin
				free_idx   = entry_idx_t'(i);
				free_found = 1'b1;
			end
		end
	end

	// enter during reset or flush is dropped
	assign alloc_en = enter_ifq.valid && free_found && !sys_reset_req && !flush_req;

	always_comb begin
		entry_load = '0;
		if (alloc_en) begin
			entry_load = entry_vec_t'(1) << free_idx; // one-hot
		end
	end

	// a retiring slot still counts as busy this cycle
	assign tb_full = &entry_busy;

endmodule

/* hdl/dpc_trace_entry.sv */
`timescale 1ns/10ps

module dpc_trace_entry (
	input  logic                   clk,
	input  logic                   arst_n,
	input  logic                   load,
	input  dpc_pkg::enter_ifq_t    enter_ifq,
	input  dpc_pkg::trace_evt_t    dcd_evt,
	input  dpc_pkg::trace_evt_t    dsptc_evt,
	input  dpc_pkg::trace_evt_t    retire_evt,
	input  logic                   sys_reset_req,
	input  logic                   flush_req,
	output dpc_pkg::entry_status_t status,
	output logic                   busy
);
	import dpc_pkg::*;

	entry_stage_e stage;
	inst_id_t     inst_id; // tag of the tracked instruction
	reg_id_t      wr_rd_id; // zero when no gpr write
	logic         dcd_hit;
	logic         dsptc_hit;
	logic         retire_hit;

	// events only count in the stage right before them
	assign dcd_hit    = dcd_evt.valid && (dcd_evt.inst_id == inst_id)
		&& (stage == STAGE_IFQ);
	assign dsptc_hit  = dsptc_evt.valid && (dsptc_evt.inst_id == inst_id)
		&& (stage == STAGE_DECODED);
	assign retire_hit = retire_evt.valid && (retire_evt.inst_id == inst_id)
		&& (stage == STAGE_DISPATCHED);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			stage <= STAGE_FREE;
		end else if (sys_reset_req) begin
			stage <= STAGE_FREE; // drop everything
		end else begin
			case (stage)
				STAGE_FREE: begin
					if (load) begin
						stage <= STAGE_IFQ;
					end
				end
				STAGE_IFQ: begin
					if (flush_req) begin
						stage <= STAGE_FREE;
					end else if (dcd_hit) begin
						stage <= STAGE_DECODED;
					end
				end
				STAGE_DECODED: begin
					if (flush_req) begin
						stage <= STAGE_FREE;
					end else if (dsptc_hit) begin
						stage <= STAGE_DISPATCHED;
					end
				end
				STAGE_DISPATCHED: begin
					// survives a flush, leaves only on retire
					if (retire_hit) begin
						stage <= STAGE_FREE;
					end
				end
				default: stage <= STAGE_FREE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (load) begin
			inst_id  <= enter_ifq.inst_id;
			wr_rd_id <= (enter_ifq.rd_vld && (enter_ifq.rd_id != '0)) ? enter_ifq.rd_id : '0;
		end
	end

	assign status.stage        = stage;
	assign status.writes_rd_id = wr_rd_id;
	assign busy                = (stage != STAGE_FREE);

endmodule

/* hdl/dpc_hazard_check.sv */
`timescale 1ns/10ps
`include "dpc_defines.svh"

module dpc_hazard_check (
	input  dpc_pkg::entry_status_t entry_status [`DPC_TRACE_INST_N],
	input  dpc_pkg::reg_id_t       dcd_rs1_id,
	input  dpc_pkg::reg_id_t       dcd_rs2_id,
	input  dpc_pkg::reg_id_t       dsptc_rd_id,
	output dpc_pkg::hazard_flags_t hazard_flags
);
	import dpc_pkg::*;

	entry_vec_t writes_gpr; // slot holds a nonzero destination
	entry_vec_t in_flight; // decoded or dispatched
	entry_vec_t dispatched;
	entry_vec_t rs1_hit;
	entry_vec_t rs2_hit;
	entry_vec_t rd_hit;

	always_comb begin
		for (int i = 0; i < `DPC_TRACE_INST_N; i++) begin
			writes_gpr[i] = |entry_status[i].writes_rd_id;
			in_flight[i]  = (entry_status[i].stage == STAGE_DECODED)
				|| (entry_status[i].stage == STAGE_DISPATCHED);
			dispatched[i] = (entry_status[i].stage == STAGE_DISPATCHED);
		end
	end

	// per-slot index compares
	always_comb begin
		for (int i = 0; i < `DPC_TRACE_INST_N; i++) begin
			rs1_hit[i] = in_flight[i] && writes_gpr[i]
				&& (entry_status[i].writes_rd_id == dcd_rs1_id);
			rs2_hit[i] = in_flight[i] && writes_gpr[i]
				&& (entry_status[i].writes_rd_id == dcd_rs2_id);
			rd_hit[i]  = dispatched[i] && writes_gpr[i]
				&& (entry_status[i].writes_rd_id == dsptc_rd_id);
		end
	end

	// Instructions still in the fetch queue are not checked here, since
	// they cannot reach decode ahead of the instruction being tested.
	assign hazard_flags.rs1_raw = |rs1_hit;
	assign hazard_flags.rs2_raw = |rs2_hit;
	assign hazard_flags.rd_waw  = |rd_hit; // older writer not yet retired

endmodule

/* hdl/dpc_monitor.sv */
`timescale 1ns/10ps
`include "dpc_defines.svh"

module dpc_monitor (
	input  logic                   clk,
	input  logic                   arst_n,
	input  logic                   sys_reset_req,
	input  logic                   flush_req,
	input  dpc_pkg::enter_ifq_t    enter_ifq, // instruction enters fetch queue
	input  dpc_pkg::trace_evt_t    dcd_evt,
	input  dpc_pkg::trace_evt_t    dsptc_evt,
	input  dpc_pkg::trace_evt_t    retire_evt,
	input  dpc_pkg::reg_id_t       dcd_rs1_id, // raw check, decode stage
	input  dpc_pkg::reg_id_t       dcd_rs2_id,
	input  dpc_pkg::reg_id_t       dsptc_rd_id, // waw check, dispatch stage
	output dpc_pkg::hazard_flags_t hazard_flags,
	output logic                   dpc_trace_tb_full
);
	import dpc_pkg::*;

	entry_vec_t    entry_busy;
	entry_vec_t    entry_load; // one-hot or zero
	entry_status_t entry_status [`DPC_TRACE_INST_N];

	dpc_alloc u_alloc (
		.entry_busy    (entry_busy),
		.enter_ifq     (enter_ifq),
		.sys_reset_req (sys_reset_req),
		.flush_req     (flush_req),
		.entry_load    (entry_load),
		.tb_full       (dpc_trace_tb_full)
	);

	// tracking table
	for (genvar i = 0; i < `DPC_TRACE_INST_N; i++) begin : g_entry
		dpc_trace_entry u_entry (
			.clk           (clk),
			.arst_n        (arst_n),
			.load          (entry_load[i]),
			.enter_ifq     (enter_ifq),
			.dcd_evt       (dcd_evt),
			.dsptc_evt     (dsptc_evt),
			.retire_evt    (retire_evt),
			.sys_reset_req (sys_reset_req),
			.flush_req     (flush_req),
			.status        (entry_status[i]),
			.busy          (entry_busy[i])
		);
	end

	dpc_hazard_check u_hazard (
		.entry_status (entry_status),
		.dcd_rs1_id   (dcd_rs1_id),
		.dcd_rs2_id   (dcd_rs2_id),
		.dsptc_rd_id  (dsptc_rd_id),
		.hazard_flags (hazard_flags)
	);

endmodule

/* tests/dpc_monitor_assertions.sv */
`timescale 1ns/10ps

module dpc_monitor_assertions (
	input logic                   clk,
	input logic                   arst_n,
	input logic                   sys_reset_req,
	input dpc_pkg::entry_vec_t    entry_load,
	input logic                   tb_full,
	input dpc_pkg::hazard_flags_t hazard_flags
);

	// at most one slot loads per cycle
	load_onehot: assert property (@(posedge clk) disable iff (!arst_n)
		$onehot0(entry_load))
		else $error("entry_load has more than one bit set: %b", entry_load);

	load_not_full: assert property (@(posedge clk) disable iff (!arst_n)
		(entry_load != '0) |-> !tb_full)
		else $error("entry loaded while the table was full");

	// table empty one cycle after a reset request
	reset_clears: assert property (@(posedge clk) disable iff (!arst_n)
		sys_reset_req |=> ((hazard_flags == '0) && !tb_full))
		else $error("flags or full still set after a reset request");

endmodule

/* tests/dpc_monitor_tb.sv */
`timescale 1ns/10ps
`include "dpc_defines.svh"

module dpc_monitor_tb;
	import dpc_pkg::*;

	localparam int N       = `DPC_TRACE_INST_N;
	localparam int TIMEOUT = 50; // cycles

	logic          clk = 1'b0;
	logic          arst_n;
	logic          sys_reset_req;
	logic          flush_req;
	enter_ifq_t    enter_ifq;
	trace_evt_t    dcd_evt;
	trace_evt_t    dsptc_evt;
	trace_evt_t    retire_evt;
	reg_id_t       dcd_rs1_id;
	reg_id_t       dcd_rs2_id;
	reg_id_t       dsptc_rd_id;
	hazard_flags_t hazard_flags;
	logic          dpc_trace_tb_full;

	logic          nxt_reset; // applied at the next tick
	logic          nxt_flush;
	enter_ifq_t    nxt_enter;
	trace_evt_t    nxt_dcd;
	trace_evt_t    nxt_dsptc;
	trace_evt_t    nxt_retire;
	reg_id_t       nxt_rs1;
	reg_id_t       nxt_rs2;
	reg_id_t       nxt_rdw;

	entry_stage_e  sh_stage [N]; // shadow table
	inst_id_t      sh_id [N];
	reg_id_t       sh_rd [N]; // zero when no gpr write
	string         test_name;
	integer        seed;

	always #4 clk = ~clk;

	dpc_monitor u_dut (
		.clk               (clk),
		.arst_n            (arst_n),
		.sys_reset_req     (sys_reset_req),
		.flush_req         (flush_req),
		.enter_ifq         (enter_ifq),
		.dcd_evt           (dcd_evt),
		.dsptc_evt         (dsptc_evt),
		.retire_evt        (retire_evt),
		.dcd_rs1_id        (dcd_rs1_id),
		.dcd_rs2_id        (dcd_rs2_id),
		.dsptc_rd_id       (dsptc_rd_id),
		.hazard_flags      (hazard_flags),
		.dpc_trace_tb_full (dpc_trace_tb_full)
	);

	bind dpc_monitor dpc_monitor_assertions u_assertions (
		.clk           (clk),
		.arst_n        (arst_n),
		.sys_reset_req (sys_reset_req),
		.entry_load    (entry_load),
		.tb_full       (dpc_trace_tb_full),
		.hazard_flags  (hazard_flags)
	);

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("Errors found");
		$fatal(1, "simulation stopped at the first failure");
	endtask

	task automatic check_hazards(input string name, input hazard_flags_t exp,
		input hazard_flags_t act);
		if (act !== exp) begin
			abort_run($sformatf("[FAIL] %s: hazard_flags expected %b actual %b", name, exp, act));
		end
	endtask

	task automatic check_full(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			abort_run($sformatf("[FAIL] %s: tb_full expected %b actual %b", name, exp, act));
		end
	endtask

	// expected outputs straight from the hazard rules
	function automatic hazard_flags_t ref_flags(input reg_id_t rs1, input reg_id_t rs2,
		input reg_id_t rdw, output logic full);
		hazard_flags_t hf;
		int            busy_cnt;
		hf       = '0;
		busy_cnt = 0;
		for (int i = 0; i < N; i++) begin
			if (sh_stage[i] != STAGE_FREE) begin
				busy_cnt++;
			end
			if (sh_rd[i] != '0 && sh_stage[i] inside {STAGE_DECODED, STAGE_DISPATCHED}) begin
				hf.rs1_raw |= (sh_rd[i] == rs1);
				hf.rs2_raw |= (sh_rd[i] == rs2);
				hf.rd_waw  |= (sh_rd[i] == rdw) && (sh_stage[i] == STAGE_DISPATCHED);
			end
		end
		full = (busy_cnt == N);
		return hf;
	endfunction

	// shadow table follows the inputs the DUT samples at this edge
	task automatic model_update();
		int slot;
		slot = -1;
		for (int i = N - 1; i >= 0; i--) begin
			if (sh_stage[i] == STAGE_FREE) begin
				slot = i;
			end
		end
		for (int i = 0; i < N; i++) begin
			case (sh_stage[i])
				STAGE_IFQ: begin
					if (flush_req) begin
						sh_stage[i] = STAGE_FREE;
					end else if (dcd_evt.valid && dcd_evt.inst_id == sh_id[i]) begin
						sh_stage[i] = STAGE_DECODED;
					end
				end
				STAGE_DECODED: begin
					if (flush_req) begin
						sh_stage[i] = STAGE_FREE;
					end else if (dsptc_evt.valid && dsptc_evt.inst_id == sh_id[i]) begin
						sh_stage[i] = STAGE_DISPATCHED;
					end
				end
				STAGE_DISPATCHED: begin
					if (retire_evt.valid && retire_evt.inst_id == sh_id[i]) begin
						sh_stage[i] = STAGE_FREE;
					end
				end
				default: ;
			endcase
		end
		if (enter_ifq.valid && !flush_req && slot >= 0) begin
			sh_stage[slot] = STAGE_IFQ;
			sh_id[slot]    = enter_ifq.inst_id;
			sh_rd[slot]    = enter_ifq.rd_vld ? enter_ifq.rd_id : '0;
		end
		if (sys_reset_req) begin
			for (int i = 0; i < N; i++) begin
				sh_stage[i] = STAGE_FREE;
			end
		end
	endtask

	// inputs the DUT samples at the next edge
	task automatic drive_inputs();
		sys_reset_req <= nxt_reset;
		flush_req     <= nxt_flush;
		enter_ifq     <= nxt_enter;
		dcd_evt       <= nxt_dcd;
		dsptc_evt     <= nxt_dsptc;
		retire_evt    <= nxt_retire;
		dcd_rs1_id    <= nxt_rs1;
		dcd_rs2_id    <= nxt_rs2;
		dsptc_rd_id   <= nxt_rdw;
		nxt_reset  = 1'b0; // strobes last one cycle
		nxt_flush  = 1'b0;
		nxt_enter  = '0;
		nxt_dcd    = '0;
		nxt_dsptc  = '0;
		nxt_retire = '0;
	endtask

	task automatic tick();
		@(posedge clk);
		model_update();
		drive_inputs();
	endtask

	task automatic send_enter(input inst_id_t id, input reg_id_t rd, input logic rd_vld);
		nxt_enter = {1'b1, id, rd, rd_vld};
		tick();
	endtask

	// kind 0 decode, 1 dispatch, 2 retire
	task automatic send_evt(input int kind, input inst_id_t id);
		case (kind)
			0: nxt_dcd = {1'b1, id};
			1: nxt_dsptc = {1'b1, id};
			default: nxt_retire = {1'b1, id};
		endcase
		tick();
	endtask

	// flag bits are rs1_raw, rs2_raw, rd_waw
	task automatic expect_state(input string name, input hazard_flags_t hf, input logic full);
		test_name = name;
		tick();
		@(negedge clk);
		check_hazards(name, hf, hazard_flags);
		check_full(name, full, dpc_trace_tb_full);
	endtask

	function automatic int rand_below(input int n);
		return $unsigned($random(seed)) % n;
	endfunction

	task automatic random_cycle();
		int       s;
		int       busy_cnt;
		logic     id_used;
		inst_id_t id;
		@(posedge clk);
		model_update(); // pick events from the state this edge leaves
		busy_cnt = 0;
		for (int i = 0; i < N; i++) begin
			busy_cnt += (sh_stage[i] != STAGE_FREE);
		end
		s = rand_below(N);
		if (sh_stage[s] == STAGE_IFQ && rand_below(2) == 0) begin
			nxt_dcd = {1'b1, sh_id[s]};
		end
		s = rand_below(N);
		if (sh_stage[s] == STAGE_DECODED && rand_below(2) == 0) begin
			nxt_dsptc = {1'b1, sh_id[s]};
		end
		s = rand_below(N);
		if (sh_stage[s] == STAGE_DISPATCHED && rand_below(3) == 0) begin
			nxt_retire = {1'b1, sh_id[s]};
		end
		if (busy_cnt < N && rand_below(2) == 0) begin
			id      = inst_id_t'(rand_below(1 << `DPC_INST_ID_WIDTH));
			id_used = 1'b1;
			while (id_used) begin // step to an id no live entry holds
				id_used = 1'b0;
				for (int i = 0; i < N; i++) begin
					id_used |= (sh_stage[i] != STAGE_FREE) && (sh_id[i] == id);
				end
				if (id_used) begin
					id = id + inst_id_t'(1);
				end
			end
			nxt_enter = {1'b1, id, reg_id_t'(rand_below(4)), rand_below(4) != 0};
		end
		nxt_flush = (rand_below(20) == 0);
		nxt_reset = (rand_below(60) == 0);
		nxt_rs1   = reg_id_t'(rand_below(4)); // small range so hits are common
		nxt_rs2   = reg_id_t'(rand_below(4));
		nxt_rdw   = reg_id_t'(rand_below(4));
		drive_inputs();
	endtask

	task automatic wait_reset_release();
		int cycles;
		cycles = 0;
		while (arst_n !== 1'b1) begin
			if (cycles == TIMEOUT) begin
				abort_run("reset was not released within the timeout");
			end else begin
				@(posedge clk);
				cycles++;
			end
		end
	endtask

	initial begin : reset_gen
		arst_n <= 1'b0;
		repeat (3) @(posedge clk);
		arst_n <= 1'b1;
	end

	initial begin : compare
		hazard_flags_t exp_hf;
		logic          exp_full;
		forever begin
			@(negedge clk);
			if (arst_n === 1'b1) begin
				exp_hf = ref_flags(dcd_rs1_id, dcd_rs2_id, dsptc_rd_id, exp_full);
				check_hazards(test_name, exp_hf, hazard_flags);
				check_full(test_name, exp_full, dpc_trace_tb_full);
			end
		end
	end

	initial begin
		seed          = 32'hf841_d105;
		test_name     = "reset";
		sys_reset_req <= 1'b0;
		flush_req     <= 1'b0;
		enter_ifq     <= '0;
		dcd_evt       <= '0;
		dsptc_evt     <= '0;
		retire_evt    <= '0;
		dcd_rs1_id    <= '0;
		dcd_rs2_id    <= '0;
		dsptc_rd_id   <= '0;
		nxt_reset  = 1'b0;
		nxt_flush  = 1'b0;
		nxt_enter  = '0;
		nxt_dcd    = '0;
		nxt_dsptc  = '0;
		nxt_retire = '0;
		nxt_rs1    = '0;
		nxt_rs2    = '0;
		nxt_rdw    = '0;
		for (int i = 0; i < N; i++) begin
			sh_stage[i] = STAGE_FREE;
			sh_id[i]    = '0;
			sh_rd[i]    = '0;
		end
		wait_reset_release();
		expect_state("after_reset", 3'b000, 1'b0);

		nxt_rs1 = 5'd5;
		nxt_rs2 = 5'd6;
		nxt_rdw = 5'd5;
		send_enter(4'd1, 5'd5, 1'b1);
		send_enter(4'd2, 5'd6, 1'b1);
		send_enter(4'd3, 5'd0, 1'b1); // writes x0
		send_enter(4'd4, 5'd7, 1'b1);
		expect_state("fill_ifq_no_raw", 3'b000, 1'b1);
		send_evt(0, 4'd1);
		expect_state("raw_rs1", 3'b100, 1'b1);
		send_evt(0, 4'd2);
		send_evt(0, 4'd3);
		expect_state("raw_rs2", 3'b110, 1'b1);
		nxt_rs1 = '0;
		nxt_rs2 = '0;
		nxt_rdw = '0;
		expect_state("reg_zero", 3'b000, 1'b1);
		nxt_rs1 = 5'd5;
		nxt_rs2 = 5'd6;
		nxt_rdw = 5'd5;
		send_evt(1, 4'd1);
		expect_state("waw_dispatch", 3'b111, 1'b1);
		send_evt(2, 4'd1);
		expect_state("retire_clears", 3'b010, 1'b0);

		send_evt(1, 4'd2);
		send_evt(0, 4'd4);
		nxt_rs1 = 5'd7;
		nxt_rdw = 5'd6;
		expect_state("before_flush", 3'b111, 1'b0);
		nxt_flush = 1'b1;
		nxt_enter = {1'b1, 4'd6, 5'd5, 1'b1}; // lost in the flush
		tick();
		expect_state("flush_keeps_dispatched", 3'b011, 1'b0);
		send_enter(4'd7, 5'd5, 1'b1);
		send_enter(4'd8, 5'd9, 1'b1);
		expect_state("flush_drops_enter", 3'b011, 1'b0);
		nxt_reset = 1'b1;
		nxt_enter = {1'b1, 4'd9, 5'd6, 1'b1};
		tick();
		expect_state("sys_reset", 3'b000, 1'b0);

		test_name = "random_mix";
		for (int n = 0; n < 2000; n++) begin
			random_cycle();
		end
		nxt_reset = 1'b1;
		tick();
		expect_state("random_mix_end", 3'b000, 1'b0);
		$display("No errors");
		$finish;
	end

endmodule

/* dpc_monitor.f */
+incdir+hdl
hdl/dpc_pkg.sv
hdl/dpc_alloc.sv
hdl/dpc_trace_entry.sv
hdl/dpc_hazard_check.sv
hdl/dpc_monitor.sv
tests/dpc_monitor_assertions.sv
tests/dpc_monitor_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the dpc_monitor testbench with Verilator.
set -e
cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir "$LOG"

verilator --binary --timing --assert \
	--top-module dpc_monitor_tb \
	-f dpc_monitor.f

status=0
./obj_dir/Vdpc_monitor_tb > "$LOG" 2>&1 || status=$?
cat "$LOG"

if grep -q "Errors found" "$LOG" || ! grep -q "^No errors$" "$LOG"; then
	echo "simulation FAILED (exit status $status), see $LOG"
	exit 1
fi
echo "simulation passed"
